/* bench/uart_checker.sv */
//******************************
// UART checker
// Decodes both serial lines, models
// both FIFOs and compares the DUT
//******************************
`timescale 1ns/1ns

module uart_checker #(
    parameter int NB_DATA    = 8,
    parameter int DEPTH      = 8,
    parameter int BIT_CYCLES = 64
) (
    input  logic                   clk,
    input  logic                   i_rst,
    input  logic                   i_rx,
    input  logic                   i_wr,
    input  logic [NB_DATA-1:0]     i_wdata,
    input  logic                   i_rd,
    input  logic                   i_tx,
    input  logic [NB_DATA-1:0]     i_rdata,
    input  uart_pkg::uart_status_t i_status,
    input  logic                   i_rx_done,
    input  logic                   i_tx_done,
    input  logic                   i_frame_err,
    output logic                   o_quiet,
    output int                     o_checks,
    output int                     o_errors
);

    logic [NB_DATA-1:0] tx_q [$];    // Bytes accepted by the TX FIFO
    logic [NB_DATA-1:0] rx_q [$];    // Bytes the RX FIFO should hold
    logic [NB_DATA-1:0] tx_byte;
    logic [NB_DATA-1:0] rx_byte;
    logic [NB_DATA-1:0] head;
    logic               tx_busy;
    logic               rx_busy;
    logic               tx_prev;
    logic               rx_prev;
    int                 tx_cyc;
    int                 rx_cyc;
    int                 tx_idx;
    int                 rx_idx;
    int                 rx_owed;     // Good frames still waiting for o_rx_done
    int                 err_owed;
    int                 done_owed;
    int                 check_cnt = 0;
    int                 error_cnt = 0;

    // Expected line level: 0 is start, 1..8 data LSB first, 9 is stop
    function automatic logic frame_bit(input logic [NB_DATA-1:0] data, input int idx);
        if (idx == 0) begin
            return 1'b0;
        end
        if (idx > NB_DATA) begin
            return 1'b1;
        end
        return data[idx-1];
    endfunction

    task automatic compare_value(input string sig, input logic [NB_DATA-1:0] expected,
                                 input logic [NB_DATA-1:0] actual);
        check_cnt++;
        if (actual !== expected) begin
            error_cnt++;
            $display("[ERROR] %0t ns %s: expected %0h, got %0h", $time, sig, expected, actual);
        end
    endtask

    task automatic report_failure(input string what);
        error_cnt++;
        $display("At %0t ns: %s", $time, what);
    endtask

    task automatic watch_tx_line();
        if (!tx_busy) begin
            if (tx_prev && !i_tx) begin
                if (tx_q.size() == 0) begin
                    report_failure("o_tx sent a start bit with no byte in the TX FIFO");
                end else begin
                    tx_byte = tx_q.pop_front();   // DUT popped on the edge that drove start
                    tx_busy = 1'b1;
                    tx_cyc  = 0;
                    tx_idx  = 0;
                end
            end else begin
                compare_value("o_tx idle", 1'b1, i_tx);   // Line rests high between frames
            end
        end else begin
            tx_cyc++;
            if (tx_cyc == BIT_CYCLES / 2 + tx_idx * BIT_CYCLES) begin
                compare_value($sformatf("o_tx bit %0d", tx_idx), frame_bit(tx_byte, tx_idx), i_tx);
                if (tx_idx == NB_DATA + 1) begin
                    tx_busy = 1'b0;
                    done_owed++;
                end
                tx_idx++;
            end
        end
        tx_prev = i_tx;
    endtask

    task automatic watch_rx_line();
        if (!rx_busy) begin
            if (rx_prev && !i_rx) begin
                rx_busy = 1'b1;
                rx_cyc  = 0;
                rx_idx  = 0;
            end
        end else begin
            rx_cyc++;
            if (rx_cyc == BIT_CYCLES / 2 + rx_idx * BIT_CYCLES) begin
                if (rx_idx >= 1 && rx_idx <= NB_DATA) begin
                    rx_byte[rx_idx-1] = i_rx;
                end
                if (rx_idx == NB_DATA + 1) begin
                    rx_busy = 1'b0;
                    if (i_rx) begin
                        rx_owed++;
                        if (rx_q.size() < DEPTH) begin
                            rx_q.push_back(rx_byte);   // Beyond full it is lost
                        end
                    end else begin
                        err_owed++;
                    end
                end
                rx_idx++;
            end
        end
        rx_prev = i_rx;
    endtask

    task automatic watch_pulses();
        if (i_rx_done) begin
            check_cnt++;
            if (rx_owed == 0) begin
                report_failure("o_rx_done pulsed with no good frame received");
            end else begin
                rx_owed--;
            end
        end
        if (i_frame_err) begin
            check_cnt++;
            if (err_owed == 0) begin
                report_failure("o_frame_err pulsed with no bad stop bit sent");
            end else begin
                err_owed--;
            end
        end
        if (i_tx_done) begin
            check_cnt++;
            if (done_owed == 0) begin
                report_failure("o_tx_done pulsed with no frame finished on o_tx");
            end else begin
                done_owed--;
            end
        end
    endtask

    // Flags reflect the state before this edge, so writes and reads come after
    task automatic compare_flags();
        compare_value("o_status.tx_empty", tx_q.size() == 0, i_status.tx_empty);
        compare_value("o_status.tx_full", tx_q.size() == DEPTH, i_status.tx_full);
        if (rx_owed == 0) begin
            compare_value("o_status.rx_empty", rx_q.size() == 0, i_status.rx_empty);
            compare_value("o_status.rx_full", rx_q.size() == DEPTH, i_status.rx_full);
        end
    endtask

    task automatic track_user();
        if (i_wr && tx_q.size() < DEPTH) begin
            tx_q.push_back(i_wdata);
        end
        if (i_rd && rx_q.size() > 0) begin
            head = rx_q.pop_front();
            compare_value("o_rdata", head, i_rdata);
        end
    endtask

    always @(posedge clk) begin
        if (i_rst) begin
            tx_q.delete();
            rx_q.delete();
            tx_busy   = 1'b0;
            rx_busy   = 1'b0;
            tx_prev   = 1'b1;
            rx_prev   = 1'b1;
            rx_owed   = 0;
            err_owed  = 0;
            done_owed = 0;
        end else begin
            watch_tx_line();
            watch_rx_line();
            watch_pulses();
            compare_flags();
            track_user();
        end
        o_quiet  <= !tx_busy && !rx_busy && tx_q.size() == 0 &&
                    rx_owed == 0 && err_owed == 0 && done_owed == 0;
        o_checks <= check_cnt;
        o_errors <= error_cnt;
    end

endmodule

/* bench/uart_tb.sv */
//******************************
// UART testbench
// Drives the line and user ports,
// checker compares the results
//******************************
`timescale 1ns/1ns

module uart_tb;

    import uart_pkg::*;

    localparam int NB_COUNTER   = 32;
    localparam int NB_DATA      = 8;
    localparam int NB_FIFO_ADDR = 3;
    localparam int FIFO_DEPTH   = 2 ** NB_FIFO_ADDR;
    localparam int TICK_CMP     = 3;
    localparam int CLK_PERIOD   = 8;
    localparam int BIT_CYCLES   = OVERSAMPLE * (TICK_CMP + 1);
    localparam int NUM_FRAMES   = 20 + 20 + 9 + 2 + 10;
    localparam int TIME_LIMIT   = (NUM_FRAMES + 10) * 10 * BIT_CYCLES * CLK_PERIOD;

    logic                  clk;
    logic                  i_rst;
    logic                  i_rx;
    logic                  i_wr;
    logic [NB_DATA-1:0]    i_wdata;
    logic                  i_rd;
    logic [NB_COUNTER-1:0] i_tick_cmp;
    logic                  o_tx;
    logic [NB_DATA-1:0]    o_rdata;
    uart_status_t          o_status;
    logic                  o_rx_done;
    logic                  o_tx_done;
    logic                  o_frame_err;
    logic                  quiet;
    int                    checks;
    int                    errors;
    int                    errors_before;
    int                    test_num = 0;
    logic [31:0]           rng;

    uart_top #(
        .NB_COUNTER   (NB_COUNTER),
        .NB_DATA      (NB_DATA),
        .NB_FIFO_ADDR (NB_FIFO_ADDR)
    ) UUT (
        .clk (clk), .i_rst (i_rst), .i_rx (i_rx), .i_wr (i_wr), .i_wdata (i_wdata),
        .i_rd (i_rd), .i_tick_cmp (i_tick_cmp), .o_tx (o_tx), .o_rdata (o_rdata),
        .o_status (o_status), .o_rx_done (o_rx_done), .o_tx_done (o_tx_done),
        .o_frame_err (o_frame_err)
    );

    uart_checker #(
        .NB_DATA    (NB_DATA),
        .DEPTH      (FIFO_DEPTH),
        .BIT_CYCLES (BIT_CYCLES)
    ) u_checker (
        .clk (clk), .i_rst (i_rst), .i_rx (i_rx), .i_wr (i_wr), .i_wdata (i_wdata),
        .i_rd (i_rd), .i_tx (o_tx), .i_rdata (o_rdata), .i_status (o_status),
        .i_rx_done (o_rx_done), .i_tx_done (o_tx_done), .i_frame_err (o_frame_err),
        .o_quiet (quiet), .o_checks (checks), .o_errors (errors)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_byte(output logic [NB_DATA-1:0] data);
        rng  = xorshift32(rng);
        data = rng[NB_DATA-1:0];
    endtask

    // One 8N1 frame on i_rx, a low stop is followed by one idle bit
    task automatic send_frame(input logic [NB_DATA-1:0] data, input logic stop_level);
        int i;
        for (i = 0; i < NB_DATA + 2; i++) begin
            @(posedge clk);
            if (i == 0) begin
                i_rx <= 1'b0;
            end else if (i <= NB_DATA) begin
                i_rx <= data[i-1];
            end else begin
                i_rx <= stop_level;
            end
            repeat (BIT_CYCLES - 1) @(posedge clk);
        end
        if (!stop_level) begin
            @(posedge clk);
            i_rx <= 1'b1;
            repeat (BIT_CYCLES - 1) @(posedge clk);
        end
    endtask

    task automatic write_byte(input logic [NB_DATA-1:0] data);
        @(posedge clk);
        while (o_status.tx_full) @(posedge clk);
        i_wr    <= 1'b1;
        i_wdata <= data;
        @(posedge clk);
        i_wr    <= 1'b0;
    endtask

    task automatic read_byte();
        @(posedge clk);
        i_rd <= 1'b1;
        @(posedge clk);
        i_rd <= 1'b0;
    endtask

    task automatic wait_quiet();
        repeat (2) @(posedge clk);
        while (!quiet) @(posedge clk);
    endtask

    task automatic begin_test();
        test_num++;
        errors_before = errors;
    endtask

    task automatic finish_test(input string name);
        repeat (2) @(posedge clk);
        $display("Test %0d %s: %s", test_num, name,
                 (errors == errors_before) ? "passed" : "failed");
    endtask

    initial begin
        logic [NB_DATA-1:0] data;
        int                 i;
        i_rst      = 1'b1;
        i_rx       = 1'b1;
        i_wr       = 1'b0;
        i_wdata    = '0;
        i_rd       = 1'b0;
        i_tick_cmp = TICK_CMP;
        rng        = 32'd64264;
        repeat (2) @(posedge clk);
        i_rst <= 1'b0;

        begin_test();
        repeat (2 * BIT_CYCLES) @(posedge clk);   // Line idle, no pulses expected
        wait_quiet();
        finish_test("reset state");

        begin_test();
        for (i = 0; i < 20; i++) begin
            next_byte(data);
            write_byte(data);
        end
        wait_quiet();
        finish_test("transmit framing");

        begin_test();
        for (i = 0; i < 20; i++) begin
            next_byte(data);
            send_frame(data, 1'b1);
            wait_quiet();
            read_byte();
        end
        wait_quiet();
        finish_test("receive path");

        begin_test();
        for (i = 0; i < FIFO_DEPTH + 1; i++) begin
            next_byte(data);
            send_frame(data, 1'b1);
        end
        wait_quiet();
        for (i = 0; i < FIFO_DEPTH; i++) begin
            read_byte();
        end
        wait_quiet();
        finish_test("receive FIFO full");

        begin_test();
        next_byte(data);
        send_frame(data, 1'b0);
        next_byte(data);
        send_frame(data, 1'b1);
        wait_quiet();
        read_byte();
        wait_quiet();
        finish_test("framing error");

        begin_test();
        next_byte(data);
        write_byte(data);
        repeat (BIT_CYCLES) @(posedge clk);   // Transmitter now mid-frame
        for (i = 0; i < FIFO_DEPTH + 1; i++) begin
            next_byte(data);
            @(posedge clk);
            i_wr    <= 1'b1;
            i_wdata <= data;
        end
        @(posedge clk);
        i_wr <= 1'b0;
        wait_quiet();
        finish_test("transmit FIFO full");

        repeat (4) @(posedge clk);
        $display("Tests: %0d, checks: %0d, errors: %0d", test_num, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Watchdog sized from the total frame count
    initial begin
        #(TIME_LIMIT);
        $display("Timeout: tests still running after %0d ns", TIME_LIMIT);
        $display("** FAIL **");
        $finish;
    end

endmodule

/* design/baud_tick_gen.sv */
//******************************
// Baud tick generator
// One-cycle tick every cmp+1 clocks
//******************************
`timescale 1ns/1ns

module baud_tick_gen #(
    parameter int NB_COUNTER = 32
) (
    input  logic                  clk,
    input  logic                  i_rst,
    input  logic [NB_COUNTER-1:0] i_tick_cmp,
    output logic                  o_tick
);

    logic [NB_COUNTER-1:0] counter;
    logic [NB_COUNTER-1:0] cmp_q;     // Compare value latched at each wrap

    assign o_tick = (counter == cmp_q);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            counter <= '0;
            cmp_q   <= i_tick_cmp;
        end else if (o_tick) begin
            counter <= '0;
            cmp_q   <= i_tick_cmp;    // New rate applies from here
        end else begin
            counter <= counter + 1'b1;
        end
    end

endmodule

/* design/sync_fifo.sv */
//******************************
// Synchronous FIFO
// First-word fall-through, head
// shown combinationally
//******************************
`timescale 1ns/1ns

module sync_fifo #(
    parameter int NB_DATA      = 8,
    parameter int NB_FIFO_ADDR = 5
) (
    input  logic               clk,
    input  logic               i_rst,
    input  logic               i_wr,
    input  logic [NB_DATA-1:0] i_wdata,
    input  logic               i_rd,
    output logic [NB_DATA-1:0] o_rdata,
    output logic               o_empty,
    output logic               o_full
);

    localparam int DEPTH = 2 ** NB_FIFO_ADDR;

    logic [NB_DATA-1:0]    mem [DEPTH];
    logic [NB_FIFO_ADDR:0] wr_ptr;     // Extra MSB marks the wrap
    logic [NB_FIFO_ADDR:0] rd_ptr;
    logic                  wr_en;
    logic                  rd_en;

    assign o_empty = (wr_ptr == rd_ptr);
    assign o_full  = (wr_ptr[NB_FIFO_ADDR] != rd_ptr[NB_FIFO_ADDR]) &&
                     (wr_ptr[NB_FIFO_ADDR-1:0] == rd_ptr[NB_FIFO_ADDR-1:0]);
    assign wr_en   = i_wr & ~o_full;   // Writes when full are lost
    assign rd_en   = i_rd & ~o_empty;
    assign o_rdata = mem[rd_ptr[NB_FIFO_ADDR-1:0]];

    always_ff @(posedge clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[NB_FIFO_ADDR-1:0]] <= i_wdata;
        end
    end

endmodule

/* design/uart_pkg.sv */
//******************************
// UART shared definitions
// Oversampling constant, line FSM
// states and FIFO status flags
//******************************

package uart_pkg;

    // Ticks per bit period, mid-bit sampling relies on it
    localparam int unsigned OVERSAMPLE = 16;

    // Tick counters span 0 to OVERSAMPLE
    localparam int unsigned NB_TICK_CNT = $clog2(OVERSAMPLE) + 1;

    // Receiver and transmitter frame position
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } line_state_t;

    // FIFO flags reported at the top level
    typedef struct packed {
        logic rx_empty;
        logic rx_full;
        logic tx_empty;
        logic tx_full;
    } uart_status_t;

endpackage

/* design/uart_rx.sv */
//******************************
// UART receiver, 8N1
// 16x oversampling, drops frames
// with a bad stop bit
//******************************
`timescale 1ns/1ns

module uart_rx #(
    parameter int NB_DATA = 8
) (
    input  logic               clk,
    input  logic               i_rst,
    input  logic               i_tick,
    input  logic               i_rx,
    output logic [NB_DATA-1:0] o_data,
    output logic               o_valid,
    output logic               o_frame_err
);

    import uart_pkg::*;

    localparam int NB_BIT_CNT = $clog2(NB_DATA);
    localparam logic [NB_TICK_CNT-1:0] MID_TICK = NB_TICK_CNT'(OVERSAMPLE / 2 - 1);
    localparam logic [NB_TICK_CNT-1:0] BIT_TICK = NB_TICK_CNT'(OVERSAMPLE - 1);
    localparam logic [NB_BIT_CNT-1:0]  LAST_BIT = NB_BIT_CNT'(NB_DATA - 1);

    line_state_t            state;
    logic [NB_TICK_CNT-1:0] tick_cnt;
    logic [NB_BIT_CNT-1:0]  bit_cnt;
    logic                   rx_meta;
    logic                   rx_sync;
    logic                   rx_prev;
    logic                   fall_edge;
    logic                   sample;

    // Two-flop synchronizer plus one stage for edge detection
    always_ff @(posedge clk) begin
        if (i_rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign fall_edge = rx_prev & ~rx_sync;
    assign sample    = i_tick && (tick_cnt == BIT_TICK);   // One bit period after last sample

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state       <= ST_IDLE;
            tick_cnt    <= '0;
            bit_cnt     <= '0;
            o_valid     <= 1'b0;
            o_frame_err <= 1'b0;
        end else begin
            o_valid     <= 1'b0;
            o_frame_err <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (fall_edge) begin
                        state    <= ST_START;
                        tick_cnt <= '0;
                    end
                end
                ST_START: begin
                    if (i_tick && tick_cnt == MID_TICK) begin
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= rx_sync ? ST_IDLE : ST_DATA;   // High here is a glitch
                    end else if (i_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                ST_DATA: begin
                    if (sample) begin
                        tick_cnt <= '0;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == LAST_BIT) begin
                            state <= ST_STOP;
                        end
                    end else if (i_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                ST_STOP: begin
                    if (sample) begin
                        tick_cnt    <= '0;
                        o_valid     <= rx_sync;
                        o_frame_err <= ~rx_sync;
                        state       <= ST_IDLE;
                    end else if (i_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Data arrives LSB first, so shift in from the top
    always_ff @(posedge clk) begin
        if (state == ST_DATA && sample) begin
            o_data <= {rx_sync, o_data[NB_DATA-1:1]};
        end
    end

endmodule

/* design/uart_top.sv */
//******************************
// UART top level
// Tick generator, RX and TX with
// a FIFO on each side
//******************************
`timescale 1ns/1ns

module uart_top #(
    parameter int NB_COUNTER   = 32,
    parameter int NB_DATA      = 8,
    parameter int NB_FIFO_ADDR = 5
) (
    input  logic                   clk,
    input  logic                   i_rst,
    input  logic                   i_rx,
    input  logic                   i_wr,
    input  logic [NB_DATA-1:0]     i_wdata,
    input  logic                   i_rd,
    input  logic [NB_COUNTER-1:0]  i_tick_cmp,
    output logic                   o_tx,
    output logic [NB_DATA-1:0]     o_rdata,
    output uart_pkg::uart_status_t o_status,
    output logic                   o_rx_done,
    output logic                   o_tx_done,
    output logic                   o_frame_err
);

    logic               tick;
    logic               tick_buffer;   // Registered copy feeding RX and TX
    logic [NB_DATA-1:0] rx_data;
    logic               rx_valid;
    logic               rx_empty;
    logic               rx_full;
    logic [NB_DATA-1:0] tx_head;
    logic               tx_pop;
    logic               tx_empty;
    logic               tx_full;

    baud_tick_gen #(
        .NB_COUNTER (NB_COUNTER)
    ) u_baud_tick_gen (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_tick_cmp (i_tick_cmp),
        .o_tick     (tick)
    );

    uart_rx #(
        .NB_DATA (NB_DATA)
    ) u_uart_rx (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_tick      (tick_buffer),
        .i_rx        (i_rx),
        .o_data      (rx_data),
        .o_valid     (rx_valid),
        .o_frame_err (o_frame_err)
    );

    sync_fifo #(
        .NB_DATA      (NB_DATA),
        .NB_FIFO_ADDR (NB_FIFO_ADDR)
    ) u_rx_fifo (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_wr    (rx_valid),
        .i_wdata (rx_data),
        .i_rd    (i_rd),
        .o_rdata (o_rdata),
        .o_empty (rx_empty),
        .o_full  (rx_full)
    );

    sync_fifo #(
        .NB_DATA      (NB_DATA),
        .NB_FIFO_ADDR (NB_FIFO_ADDR)
    ) u_tx_fifo (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_wr    (i_wr),
        .i_wdata (i_wdata),
        .i_rd    (tx_pop),
        .o_rdata (tx_head),
        .o_empty (tx_empty),
        .o_full  (tx_full)
    );

    uart_tx #(
        .NB_DATA (NB_DATA)
    ) u_uart_tx (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_tick  (tick_buffer),
        .i_empty (tx_empty),
        .i_data  (tx_head),
        .o_pop   (tx_pop),
        .o_tx    (o_tx),
        .o_done  (o_tx_done)
    );

    always_ff @(posedge clk) begin
        if (i_rst) begin
            tick_buffer <= 1'b0;
            o_rx_done   <= 1'b0;
        end else begin
            tick_buffer <= tick;
            o_rx_done   <= rx_valid;   // Lags the FIFO write by one cycle
        end
    end

    assign o_status = '{rx_empty: rx_empty, rx_full: rx_full,
                        tx_empty: tx_empty, tx_full: tx_full};

endmodule

/* design/uart_tx.sv */
//******************************
// UART transmitter, 8N1
// Pulls bytes from the TX FIFO
// and serializes them
//******************************
`timescale 1ns/1ns

module uart_tx #(
    parameter int NB_DATA = 8
) (
    input  logic               clk,
    input  logic               i_rst,
    input  logic               i_tick,
    input  logic               i_empty,
    input  logic [NB_DATA-1:0] i_data,
    output logic               o_pop,
    output logic               o_tx,
    output logic               o_done
);

    import uart_pkg::*;

    localparam int NB_BIT_CNT = $clog2(NB_DATA);
    localparam logic [NB_TICK_CNT-1:0] BIT_TICK = NB_TICK_CNT'(OVERSAMPLE - 1);
    localparam logic [NB_BIT_CNT-1:0]  LAST_BIT = NB_BIT_CNT'(NB_DATA - 1);

    line_state_t            state;
    logic [NB_TICK_CNT-1:0] tick_cnt;
    logic [NB_BIT_CNT-1:0]  bit_cnt;
    logic [NB_DATA-1:0]     shift_reg;
    logic                   bit_end;

    assign bit_end = i_tick && (tick_cnt == BIT_TICK);

    // Take the next byte on a tick when idle, or right at the end of a stop bit
    assign o_pop = !i_empty && ((state == ST_IDLE && i_tick) || (state == ST_STOP && bit_end));

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state    <= ST_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            o_tx     <= 1'b1;
            o_done   <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (i_tick && state != ST_IDLE) begin
                tick_cnt <= bit_end ? '0 : tick_cnt + 1'b1;
            end
            case (state)
                ST_IDLE: begin
                    if (o_pop) begin
                        o_tx     <= 1'b0;           // Start bit
                        tick_cnt <= '0;
                        state    <= ST_START;
                    end
                end
                ST_START: begin
                    if (bit_end) begin
                        o_tx    <= shift_reg[0];
                        bit_cnt <= '0;
                        state   <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (bit_end && bit_cnt == LAST_BIT) begin
                        o_tx  <= 1'b1;              // Stop bit
                        state <= ST_STOP;
                    end else if (bit_end) begin
                        o_tx    <= shift_reg[0];
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                ST_STOP: begin
                    if (bit_end) begin
                        o_done <= 1'b1;
                        o_tx   <= ~o_pop;           // Back-to-back start if more queued
                        state  <= o_pop ? ST_START : ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (o_pop) begin
            shift_reg <= i_data;
        end else if (bit_end && (state == ST_START || state == ST_DATA)) begin
            shift_reg <= shift_reg >> 1;
        end
    end

endmodule

/* tb.f */
design/uart_pkg.sv
design/baud_tick_gen.sv
design/uart_rx.sv
design/uart_tx.sv
design/sync_fifo.sv
design/uart_top.sv
bench/uart_checker.sv
bench/uart_tb.sv
